/* rx_ppe.f */
common/rx_ppe_pkg.sv
common/rx_ppe_csr_pkg.sv
parser/rx_ppe_parser.sv
parser/rx_ppe_classifier.sv
csr/rx_ppe_csr.sv
source/rx_ppe_stats.sv
source/rx_ppe.sv
sim/rx_ppe_clk_gen.sv
sim/rx_ppe_tb.sv

/* sim/rx_ppe_tb.sv */
// Self-checking testbench for rx_ppe, drives packets and register accesses, checks by assertions
`timescale 1ns/1ps

module rx_ppe_tb;

   localparam int READ_LIMIT  = 8;
   localparam int DRAIN_LIMIT = 200;

   // Expected record and the cycle in which it must appear
   typedef struct packed {
      logic [31:0]          due;
      rx_ppe_pkg::rx_meta_t m;
   } exp_entry_t;

   logic                      cclk;
   logic                      rst;
   rx_ppe_pkg::igr_word_t     igr;
   logic                      csr_wr;
   logic                      csr_rd;
   rx_ppe_csr_pkg::csr_addr_t csr_addr;
   logic [31:0]               csr_wdata;
   logic [31:0]               csr_rdata;
   logic                      csr_rvalid;
   rx_ppe_pkg::rx_meta_t      meta;

   // Own copy of the configuration, follows every write
   logic [15:0]               cfg_port_en;
   rx_ppe_pkg::ethertype_t    cfg_match_etype;
   rx_ppe_pkg::tc_t           cfg_default_tc;
   rx_ppe_pkg::tc_t           cfg_match_tc;

   exp_entry_t                exp_q[$];
   exp_entry_t                head;
   logic                      head_ok = 1'b0;
   logic [31:0]               cyc = '0;
   logic [31:0]               rd_exp = '0;
   int                        n_pass = 0;
   int                        n_drop = 0;
   int                        check_errs = 0;
   int                        other_errs = 0;

   rx_ppe_clk_gen clk_gen_i (.clk(cclk));

   rx_ppe dut_i (
      .cclk       (cclk),
      .rst        (rst),
      .igr        (igr),
      .csr_wr     (csr_wr),
      .csr_rd     (csr_rd),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .csr_rdata  (csr_rdata),
      .csr_rvalid (csr_rvalid),
      .meta       (meta)
   );

   // ======================================================================
   // Checkers
   // ======================================================================
   always @(posedge cclk) begin
      cyc <= cyc + 32'd1;
   end

   // Record on meta is stable mid-cycle, take its expectation off the queue then
   always @(negedge cclk) begin
      if (!rst && meta.valid) begin
         head_ok = (exp_q.size() > 0);
         if (head_ok) begin
            head = exp_q.pop_front();
         end else begin
            head = '0;
         end
      end
   end

   a_meta_latency : assert property (@(posedge cclk) disable iff (rst)
      igr.valid && igr.eop |-> ##2 meta.valid)
      else begin
         $display("CHECK FAILED t=%0t: no metadata 2 cycles after eop", $time);
         check_errs++;
      end

   a_meta_source : assert property (@(posedge cclk) disable iff (rst)
      meta.valid |-> $past(igr.valid && igr.eop, 2))
      else begin
         $display("CHECK FAILED t=%0t: metadata without an eop 2 cycles before", $time);
         check_errs++;
      end

   a_meta_value : assert property (@(posedge cclk) disable iff (rst)
      meta.valid |-> head_ok && meta == head.m && cyc == head.due)
      else begin
         $display("CHECK FAILED t=%0t: meta %h, expected %h due in cycle %0d",
                  $time, $sampled(meta), $sampled(head.m), $sampled(head.due));
         check_errs++;
      end

   a_read_data : assert property (@(posedge cclk) disable iff (rst)
      csr_rvalid |-> csr_rdata == rd_exp)
      else begin
         $display("CHECK FAILED t=%0t: csr_rdata %h, expected %h",
                  $time, $sampled(csr_rdata), $sampled(rd_exp));
         check_errs++;
      end

   // Read data valid exactly one cycle after each read strobe, and never otherwise
   a_read_latency : assert property (@(posedge cclk) disable iff (rst)
      csr_rvalid == $past(csr_rd))
      else begin
         $display("CHECK FAILED t=%0t: csr_rvalid does not follow csr_rd by one cycle",
                  $time);
         check_errs++;
      end

   // Outputs quiet on the first cycle out of reset
   a_reset_state : assert property (@(posedge cclk)
      $fell(rst) |-> !meta.valid && !csr_rvalid && !dut_i.stats_clr)
      else begin
         $display("CHECK FAILED t=%0t: outputs active right after reset", $time);
         check_errs++;
      end

   // ======================================================================
   // Stimulus helpers
   // ======================================================================
   // Edge plus 1 ns, where inputs change and registered outputs are read
   task automatic tick();
      @(posedge cclk);
      #1;
   endtask

   task automatic idle(input int n);
      igr = '0;
      repeat (n) tick();
   endtask

   task automatic csr_write(input rx_ppe_csr_pkg::csr_addr_t addr, input logic [31:0] data);
      csr_wr    = 1'b1;
      csr_addr  = addr;
      csr_wdata = data;
      case (addr)
         rx_ppe_csr_pkg::ADDR_PORT_EN:     cfg_port_en = data[15:0];
         rx_ppe_csr_pkg::ADDR_MATCH_ETYPE: cfg_match_etype = data[15:0];
         rx_ppe_csr_pkg::ADDR_TC_CFG: begin
            cfg_default_tc = data[2:0];
            cfg_match_tc   = data[10:8];
         end
         rx_ppe_csr_pkg::ADDR_STATS_CLR: begin
            n_pass = 0;
            n_drop = 0;
         end
         default: begin
         end
      endcase
      tick();
      csr_wr = 1'b0;
   endtask

   // Expected data stays put until the returned word has been sampled
   task automatic csr_read(input rx_ppe_csr_pkg::csr_addr_t addr, input logic [31:0] expected);
      int n;
      n        = 0;
      csr_rd   = 1'b1;
      csr_addr = addr;
      rd_exp   = expected;
      tick();
      csr_rd = 1'b0;
      while (!csr_rvalid) begin
         if (n == READ_LIMIT) begin
            $display("Timeout: no csr_rvalid for the read of address %0d", addr);
            other_errs++;
            break;
         end
         tick();
         n++;
      end
      tick();
   endtask

   // Classification rules applied to what was sent
   function automatic rx_ppe_pkg::rx_meta_t expect_meta(input rx_ppe_pkg::port_t port,
      input logic vlan, input rx_ppe_pkg::tc_t pcp, input rx_ppe_pkg::vid_t vid,
      input rx_ppe_pkg::ethertype_t etype, input int len);
      rx_ppe_pkg::rx_meta_t m;
      logic                 is_runt;
      // Eop on word 3, or on word 4 behind a tag, is still short
      is_runt = (len <= (vlan ? 5 : 4));
      m       = '0;
      m.valid = 1'b1;
      m.port  = port;
      if (!is_runt) begin
         m.ethertype = etype;
         m.vid       = vlan ? vid : '0;
      end
      if (!cfg_port_en[port]) begin
         m.drop        = 1'b1;
         m.drop_reason = rx_ppe_pkg::port_disabled;
      end else if (is_runt) begin
         m.drop        = 1'b1;
         m.drop_reason = rx_ppe_pkg::runt;
      end else if (vlan) begin
         m.tc = pcp;
      end else if (etype == cfg_match_etype) begin
         m.tc = cfg_match_tc;
      end else begin
         m.tc = cfg_default_tc;
      end
      return m;
   endfunction

   // Ethertype that is never a VLAN TPID, the match value a third of the time
   function automatic rx_ppe_pkg::ethertype_t pick_etype();
      rx_ppe_pkg::ethertype_t e;
      case ($urandom % 3)
         0:       e = cfg_match_etype;
         1:       e = 16'h0800;
         default: e = 16'($urandom);
      endcase
      if (e == rx_ppe_pkg::TPID_VLAN) begin
         e = 16'h86DD;
      end
      return e;
   endfunction

   task automatic send_packet(input rx_ppe_pkg::port_t port, input logic vlan,
      input rx_ppe_pkg::tc_t pcp, input rx_ppe_pkg::vid_t vid,
      input rx_ppe_pkg::ethertype_t etype, input int len);
      rx_ppe_pkg::igr_word_t w;
      exp_entry_t            e;
      e.m = expect_meta(port, vlan, pcp, vid, etype, len);
      for (int i = 0; i < len; i++) begin
         // Occasional hole inside the packet
         if (i > 0 && ($urandom % 4) == 0) begin
            idle(1);
         end
         w.valid = 1'b1;
         w.sop   = (i == 0);
         w.eop   = (i == len - 1);
         w.port  = port;
         w.data  = $urandom;
         if (i == rx_ppe_pkg::ETYPE_WORD) begin
            if (vlan) begin
               w.data = {rx_ppe_pkg::TPID_VLAN, pcp, 1'b0, vid};
            end else begin
               w.data[31:16] = etype;
            end
         end
         if (i == rx_ppe_pkg::INNER_WORD && vlan) begin
            w.data[31:16] = etype;
         end
         igr = w;
         if (w.eop) begin
            // Sampled on the next edge, record seen two edges after that
            e.due = cyc + 32'd2;
            exp_q.push_back(e);
            if (e.m.drop) begin
               n_drop++;
            end else begin
               n_pass++;
            end
         end
         tick();
      end
      igr = '0;
   endtask

   // Random tag fields and ethertype, then a gap of zero to two cycles
   task automatic random_packet(input logic vlan, input rx_ppe_pkg::port_t port, input int len);
      send_packet(port, vlan, 3'($urandom), 12'($urandom), pick_etype(), len);
      idle($urandom % 3);
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_q.size() != 0) begin
         if (n == DRAIN_LIMIT) begin
            $display("Timeout: %0d metadata records never arrived", exp_q.size());
            other_errs++;
            break;
         end
         tick();
         n++;
      end
      // Counters settle one cycle after the last record
      idle(2);
   endtask

   // ======================================================================
   // Test sequence
   // ======================================================================
   initial begin
      void'($urandom(32'h569d));
      rst             = 1'b1;
      igr             = '0;
      csr_wr          = 1'b0;
      csr_rd          = 1'b0;
      csr_addr        = '0;
      csr_wdata       = '0;
      cfg_port_en     = 16'hFFFF;
      cfg_match_etype = 16'h88F7;
      cfg_default_tc  = 3'd0;
      cfg_match_tc    = 3'd0;
      repeat (10) tick();
      rst = 1'b0;
      idle(2);

      // Reset values, counters, clear address and an unused address
      csr_read(rx_ppe_csr_pkg::ADDR_PORT_EN, 32'h0000_FFFF);
      csr_read(rx_ppe_csr_pkg::ADDR_MATCH_ETYPE, 32'h0000_88F7);
      csr_read(rx_ppe_csr_pkg::ADDR_TC_CFG, 32'h0);
      csr_read(rx_ppe_csr_pkg::ADDR_PASS_CNT, 32'h0);
      csr_read(rx_ppe_csr_pkg::ADDR_DROP_CNT, 32'h0);
      csr_read(rx_ppe_csr_pkg::ADDR_STATS_CLR, 32'h0);
      csr_read(4'd9, 32'h0);

      // default_tc 3, match_tc 5
      csr_write(rx_ppe_csr_pkg::ADDR_TC_CFG, 32'h0000_0503);
      csr_write(rx_ppe_csr_pkg::ADDR_MATCH_ETYPE, 32'h0000_88B5);
      csr_read(rx_ppe_csr_pkg::ADDR_TC_CFG, 32'h0000_0503);
      csr_read(rx_ppe_csr_pkg::ADDR_MATCH_ETYPE, 32'h0000_88B5);

      // Untagged, then tagged, with back to back runs
      for (int i = 0; i < 24; i++) begin
         random_packet(1'b0, 4'($urandom), 5 + int'($urandom % 8));
      end
      for (int i = 0; i < 16; i++) begin
         random_packet(1'b1, 4'($urandom), 6 + int'($urandom % 8));
      end

      // Port 5 disabled, then enabled again
      drain();
      csr_write(rx_ppe_csr_pkg::ADDR_PORT_EN, 32'h0000_FFDF);
      csr_read(rx_ppe_csr_pkg::ADDR_PORT_EN, 32'h0000_FFDF);
      for (int i = 0; i < 8; i++) begin
         random_packet(1'($urandom), (i % 2) ? 4'd5 : 4'($urandom), 6 + int'($urandom % 4));
      end
      drain();
      csr_write(rx_ppe_csr_pkg::ADDR_PORT_EN, 32'h0000_FFFF);
      for (int i = 0; i < 4; i++) begin
         random_packet(1'($urandom), 4'd5, 6 + int'($urandom % 4));
      end

      // Short packets of every runt length
      for (int len = 1; len <= 4; len++) begin
         random_packet(1'b0, 4'($urandom), len);
      end
      for (int len = 1; len <= 5; len++) begin
         random_packet(1'b1, 4'($urandom), len);
      end

      // Counters, then clear
      drain();
      csr_read(rx_ppe_csr_pkg::ADDR_PASS_CNT, 32'(n_pass));
      csr_read(rx_ppe_csr_pkg::ADDR_DROP_CNT, 32'(n_drop));
      csr_write(rx_ppe_csr_pkg::ADDR_STATS_CLR, 32'h1);
      idle(2);
      csr_read(rx_ppe_csr_pkg::ADDR_PASS_CNT, 32'h0);
      csr_read(rx_ppe_csr_pkg::ADDR_DROP_CNT, 32'h0);

      idle(4);
      $display("check errors: %0d, other errors: %0d", check_errs, other_errs);
      if (check_errs == 0 && other_errs == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   // Run time limit
   initial begin
      #2_000_000;
      $display("Simulation time limit reached before the test sequence ended");
      $display("check errors: %0d, other errors: %0d", check_errs, other_errs + 1);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

/* sim/rx_ppe_clk_gen.sv */
// Testbench clock source for rx_ppe, free running with a 20 ns period, starting low
`timescale 1ns/1ps

module rx_ppe_clk_gen (
   output logic clk
);

   // Half of the 20 ns period
   localparam realtime HALF_PERIOD = 10.0;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

endmodule

/* source/rx_ppe.sv */
// Receive header parser top, ingress words in and one metadata record per packet out
`timescale 1ns/1ps

module rx_ppe (
   input  logic                      cclk,
   input  logic                      rst,
   // Ingress words
   input  rx_ppe_pkg::igr_word_t     igr,
   // Register access
   input  logic                      csr_wr,
   input  logic                      csr_rd,
   input  rx_ppe_csr_pkg::csr_addr_t csr_addr,
   input  logic [31:0]               csr_wdata,
   output logic [31:0]               csr_rdata,
   output logic                      csr_rvalid,
   // Metadata toward the downstream stage
   output rx_ppe_pkg::rx_meta_t      meta
);

   // Parser to classifier
   rx_ppe_pkg::parsed_hdr_t hdr;
   // Register block to classifier
   rx_ppe_csr_pkg::cfg_t    cfg;
   // Classifier and register block to statistics
   logic                    pass_pulse;
   logic                    drop_pulse;
   logic                    stats_clr;
   // Counter readback
   logic [31:0]             pass_cnt;
   logic [31:0]             drop_cnt;

   // ======================================================================
   // Datapath, eop word to meta.valid in two cycles
   // ======================================================================
   rx_ppe_parser parser_i (
      .cclk (cclk),
      .rst  (rst),
      .igr  (igr),
      .hdr  (hdr)
   );

   rx_ppe_classifier classifier_i (
      .cclk       (cclk),
      .rst        (rst),
      .hdr        (hdr),
      .cfg        (cfg),
      .meta       (meta),
      .pass_pulse (pass_pulse),
      .drop_pulse (drop_pulse)
   );

   // ======================================================================
   // Configuration and status
   // ======================================================================
   rx_ppe_csr csr_i (
      .cclk       (cclk),
      .rst        (rst),
      .csr_wr     (csr_wr),
      .csr_rd     (csr_rd),
      .csr_addr   (csr_addr),
      .csr_wdata  (csr_wdata),
      .csr_rdata  (csr_rdata),
      .csr_rvalid (csr_rvalid),
      .cfg        (cfg),
      .stats_clr  (stats_clr),
      .pass_cnt   (pass_cnt),
      .drop_cnt   (drop_cnt)
   );

   rx_ppe_stats stats_i (
      .cclk       (cclk),
      .rst        (rst),
      .pass_pulse (pass_pulse),
      .drop_pulse (drop_pulse),
      .stats_clr  (stats_clr),
      .pass_cnt   (pass_cnt),
      .drop_cnt   (drop_cnt)
   );

endmodule

/* source/rx_ppe_stats.sv */
// Saturating pass and drop packet counters, cleared by a pulse from the register block
`timescale 1ns/1ps

module rx_ppe_stats (
   input  logic        cclk,
   input  logic        rst,
   input  logic        pass_pulse,
   input  logic        drop_pulse,
   input  logic        stats_clr,
   output logic [31:0] pass_cnt,
   output logic [31:0] drop_cnt
);

   // Index 0 counts passes, index 1 drops
   logic [1:0][31:0] cnt;
   logic [1:0]       inc;

   assign inc = {drop_pulse, pass_pulse};

   // ======================================================================
   // Counters, clear wins over an increment in the same cycle
   // ======================================================================
   always_ff @(posedge cclk) begin
      if (rst || stats_clr) begin
         cnt <= '0;
      end else begin
         for (int i = 0; i < 2; i++) begin
            // Stick at all ones
            if (inc[i] && cnt[i] != '1) begin
               cnt[i] <= cnt[i] + 32'd1;
            end
         end
      end
   end

   assign pass_cnt = cnt[0];
   assign drop_cnt = cnt[1];

endmodule

/* csr/rx_ppe_csr.sv */
// Configuration registers and status readback behind a plain read/write strobe interface
`timescale 1ns/1ps

module rx_ppe_csr (
   input  logic                      cclk,
   input  logic                      rst,
   input  logic                      csr_wr,
   input  logic                      csr_rd,
   input  rx_ppe_csr_pkg::csr_addr_t csr_addr,
   input  logic [31:0]               csr_wdata,
   output logic [31:0]               csr_rdata,
   output logic                      csr_rvalid,
   // Held continuously toward the classifier
   output rx_ppe_csr_pkg::cfg_t      cfg,
   // One cycle after the clear write
   output logic                      stats_clr,
   input  logic [31:0]               pass_cnt,
   input  logic [31:0]               drop_cnt
);

   logic [31:0] rdata_n;

   // ======================================================================
   // Writes
   // ======================================================================
   always_ff @(posedge cclk) begin
      if (rst) begin
         cfg.port_en     <= rx_ppe_csr_pkg::PORT_EN_RST;
         cfg.match_etype <= rx_ppe_csr_pkg::MATCH_ETYPE_RST;
         cfg.default_tc  <= rx_ppe_csr_pkg::TC_CFG_RST[2:0];
         cfg.match_tc    <= rx_ppe_csr_pkg::TC_CFG_RST[10:8];
      end else if (csr_wr) begin
         case (csr_addr)
            rx_ppe_csr_pkg::ADDR_PORT_EN: begin
               cfg.port_en <= csr_wdata[rx_ppe_pkg::NUM_PORTS-1:0];
            end
            rx_ppe_csr_pkg::ADDR_MATCH_ETYPE: begin
               cfg.match_etype <= csr_wdata[15:0];
            end
            rx_ppe_csr_pkg::ADDR_TC_CFG: begin
               cfg.default_tc <= csr_wdata[2:0];
               cfg.match_tc   <= csr_wdata[10:8];
            end
            default: begin
               // Counters and clear are not stored here
            end
         endcase
      end
   end

   // Clear strobe, counters see it on the following edge
   always_ff @(posedge cclk) begin
      if (rst) begin
         stats_clr <= 1'b0;
      end else begin
         stats_clr <= csr_wr && (csr_addr == rx_ppe_csr_pkg::ADDR_STATS_CLR);
      end
   end

   // ======================================================================
   // Reads
   // ======================================================================
   always_comb begin
      rdata_n = '0;
      case (csr_addr)
         rx_ppe_csr_pkg::ADDR_PORT_EN:     rdata_n = 32'(cfg.port_en);
         rx_ppe_csr_pkg::ADDR_MATCH_ETYPE: rdata_n = 32'(cfg.match_etype);
         rx_ppe_csr_pkg::ADDR_TC_CFG: begin
            rdata_n[2:0]  = cfg.default_tc;
            rdata_n[10:8] = cfg.match_tc;
         end
         rx_ppe_csr_pkg::ADDR_PASS_CNT:    rdata_n = pass_cnt;
         rx_ppe_csr_pkg::ADDR_DROP_CNT:    rdata_n = drop_cnt;
         // Clear address and holes read zero
         default:                          rdata_n = '0;
      endcase
   end

   // Data one cycle after the read strobe
   always_ff @(posedge cclk) begin
      if (csr_rd) begin
         csr_rdata <= rdata_n;
      end
      if (rst) begin
         csr_rvalid <= 1'b0;
      end else begin
         csr_rvalid <= csr_rd;
      end
   end

   // Host issues one access per cycle
   a_no_wr_rd : assert property (@(posedge cclk) disable iff (rst)
      !(csr_wr && csr_rd))
      else $error("csr_wr and csr_rd in the same cycle");

endmodule

/* parser/rx_ppe_classifier.sv */
// Traffic class and drop decision per parsed header, registered into the metadata record
`timescale 1ns/1ps

module rx_ppe_classifier (
   input  logic                    cclk,
   input  logic                    rst,
   input  rx_ppe_pkg::parsed_hdr_t hdr,
   input  rx_ppe_csr_pkg::cfg_t    cfg,
   output rx_ppe_pkg::rx_meta_t    meta,
   // One per record, toward the counters
   output logic                    pass_pulse,
   output logic                    drop_pulse
);

   rx_ppe_pkg::rx_meta_t meta_n;

   // ======================================================================
   // Decision, port enable first, then runt, then class selection
   // ======================================================================
   always_comb begin
      meta_n           = '0;
      meta_n.valid     = hdr.valid;
      meta_n.port      = hdr.port;
      // Ethertype and vid ride along on drops too, runts already zero
      meta_n.ethertype = hdr.ethertype;
      meta_n.vid       = hdr.vid;
      if (!cfg.port_en[hdr.port]) begin
         meta_n.drop        = 1'b1;
         meta_n.drop_reason = rx_ppe_pkg::port_disabled;
      end else if (hdr.runt) begin
         meta_n.drop        = 1'b1;
         meta_n.drop_reason = rx_ppe_pkg::runt;
      end else if (hdr.vlan_present) begin
         // Tagged frames keep their priority code point
         meta_n.tc = hdr.pcp;
      end else if (hdr.ethertype == cfg.match_etype) begin
         meta_n.tc = cfg.match_tc;
      end else begin
         meta_n.tc = cfg.default_tc;
      end
   end

   // ======================================================================
   // Record register
   // ======================================================================
   always_ff @(posedge cclk) begin
      meta <= meta_n;
      if (rst) begin
         meta.valid <= 1'b0;
      end
   end

   // Counter pulses line up with meta.valid
   assign pass_pulse = meta.valid && !meta.drop;
   assign drop_pulse = meta.valid && meta.drop;

   // A dropped record always names its reason
   a_drop_has_reason : assert property (@(posedge cclk) disable iff (rst)
      meta.valid && meta.drop |-> meta.drop_reason != rx_ppe_pkg::none)
      else $error("drop without a drop reason");

endmodule

/* parser/rx_ppe_parser.sv */
// Ethernet header walker, registers one parsed header the cycle after each eop word
`timescale 1ns/1ps

module rx_ppe_parser (
   input  logic                    cclk,
   input  logic                    rst,
   input  rx_ppe_pkg::igr_word_t   igr,
   output rx_ppe_pkg::parsed_hdr_t hdr
);

   rx_ppe_pkg::parse_state_e state;
   rx_ppe_pkg::parse_state_e state_n;
   // Index of the next word, saturates at the inner ethertype word
   logic [2:0]               cnt;
   logic [2:0]               cnt_n;
   // Header under construction, valid marks the final ethertype as seen
   rx_ppe_pkg::parsed_hdr_t  work;
   rx_ppe_pkg::parsed_hdr_t  work_n;
   logic [15:0]              upper;
   logic [15:0]              lower;
   // Header complete before the current word
   logic                     hdr_done;
   // Eop of a packet that was opened by a sop
   logic                     pkt_end;

   assign upper    = igr.data[31:16];
   assign lower    = igr.data[15:0];
   assign hdr_done = !igr.sop && work.valid;
   assign pkt_end  = igr.valid && igr.eop && (igr.sop || state != rx_ppe_pkg::idle);

   // ======================================================================
   // Next state and header fields
   // ======================================================================
   always_comb begin
      state_n = state;
      cnt_n   = cnt;
      work_n  = work;
      if (igr.valid) begin
         if (igr.sop) begin
            // Word 0 restarts the walk whatever came before
            state_n     = rx_ppe_pkg::skip_mac;
            cnt_n       = 3'd1;
            work_n      = '0;
            work_n.port = igr.port;
         end else begin
            if (cnt != 3'(rx_ppe_pkg::INNER_WORD)) begin
               cnt_n = cnt + 3'd1;
            end
            case (state)
               rx_ppe_pkg::skip_mac: begin
                  // MAC addresses, nothing kept
                  if (cnt_n == 3'(rx_ppe_pkg::ETYPE_WORD)) begin
                     state_n = rx_ppe_pkg::etype;
                  end
               end
               rx_ppe_pkg::etype: begin
                  if (upper == rx_ppe_pkg::TPID_VLAN) begin
                     // Tag in the lower half, real ethertype one word later
                     work_n.vlan_present = 1'b1;
                     work_n.pcp          = lower[15:13];
                     work_n.vid          = lower[11:0];
                     state_n             = rx_ppe_pkg::inner;
                  end else begin
                     work_n.ethertype = upper;
                     work_n.valid     = 1'b1;
                     state_n          = rx_ppe_pkg::payload;
                  end
               end
               rx_ppe_pkg::inner: begin
                  work_n.ethertype = upper;
                  work_n.valid     = 1'b1;
                  state_n          = rx_ppe_pkg::payload;
               end
               default: begin
                  // Payload words, or stray words with no sop
               end
            endcase
         end
         if (igr.eop) begin
            state_n = rx_ppe_pkg::idle;
         end
      end
   end

   always_ff @(posedge cclk) begin
      if (rst) begin
         state <= rx_ppe_pkg::idle;
         cnt   <= '0;
      end else begin
         state <= state_n;
         cnt   <= cnt_n;
      end
   end

   always_ff @(posedge cclk) begin
      work <= work_n;
   end

   // ======================================================================
   // Output record
   // ======================================================================
   // Runt means eop on or before the final ethertype word, fields then read zero
   always_ff @(posedge cclk) begin
      if (pkt_end) begin
         hdr      <= work_n;
         hdr.runt <= !hdr_done;
         if (!hdr_done) begin
            hdr.ethertype <= '0;
            hdr.vid       <= '0;
         end
      end
      if (rst) begin
         hdr.valid <= 1'b0;
      end else begin
         hdr.valid <= pkt_end;
      end
   end

   // Ingress never opens a packet over an unfinished one
   a_sop_in_pkt : assert property (@(posedge cclk) disable iff (rst)
      igr.valid && igr.sop |-> state == rx_ppe_pkg::idle)
      else $error("sop while a packet is still open");

   // Header record only one cycle after an eop word
   a_hdr_after_eop : assert property (@(posedge cclk) disable iff (rst)
      hdr.valid |-> $past(igr.valid && igr.eop))
      else $error("parsed header without a preceding eop");

endmodule

/* common/rx_ppe_csr_pkg.sv */
// Register map, reset values and configuration record of the rx_ppe register block
package rx_ppe_csr_pkg;

   typedef logic [3:0] csr_addr_t;

   // ======================================================================
   // Register addresses
   // ======================================================================
   localparam csr_addr_t ADDR_PORT_EN     = 4'd0;
   localparam csr_addr_t ADDR_MATCH_ETYPE = 4'd1;
   // default_tc in 2..0, match_tc in 10..8
   localparam csr_addr_t ADDR_TC_CFG      = 4'd2;
   localparam csr_addr_t ADDR_PASS_CNT    = 4'd3;
   localparam csr_addr_t ADDR_DROP_CNT    = 4'd4;
   // Write only, any data clears both counters
   localparam csr_addr_t ADDR_STATS_CLR   = 4'd5;

   // ======================================================================
   // Reset values
   // ======================================================================
   // Every port enabled out of reset
   localparam logic [rx_ppe_pkg::NUM_PORTS-1:0] PORT_EN_RST = '1;
   // PTP ethertype
   localparam rx_ppe_pkg::ethertype_t MATCH_ETYPE_RST = 16'h88F7;
   localparam logic [31:0] TC_CFG_RST = 32'h0000_0000;

   // Live configuration toward the classifier
   typedef struct packed {
      logic [rx_ppe_pkg::NUM_PORTS-1:0] port_en;
      rx_ppe_pkg::ethertype_t           match_etype;
      rx_ppe_pkg::tc_t                  default_tc;
      rx_ppe_pkg::tc_t                  match_tc;
   } cfg_t;

endpackage

/* common/rx_ppe_pkg.sv */
// Packet, header and metadata types shared by the rx_ppe datapath and its testbench
package rx_ppe_pkg;

   // ======================================================================
   // Field widths
   // ======================================================================
   typedef logic [3:0]  port_t;
   typedef logic [2:0]  tc_t;
   typedef logic [15:0] ethertype_t;
   typedef logic [11:0] vid_t;

   // Header layout
   localparam logic [15:0] TPID_VLAN  = 16'h8100;
   // Ethertype or TPID in the upper half of this word
   localparam int          ETYPE_WORD = 3;
   // Inner ethertype behind a VLAN tag
   localparam int          INNER_WORD = 4;
   localparam int          NUM_PORTS  = 16;

   // One ingress word, one per cycle
   typedef struct packed {
      logic        valid;
      logic        sop;
      logic        eop;
      port_t       port;
      logic [31:0] data;
   } igr_word_t;

   // Parser to classifier record
   typedef struct packed {
      logic       valid;
      port_t      port;
      ethertype_t ethertype;
      logic       vlan_present;
      tc_t        pcp;
      vid_t       vid;
      logic       runt;
   } parsed_hdr_t;

   // none must stay at zero, a cleared record reads as no drop
   typedef enum logic [1:0] {
      none          = 2'd0,
      port_disabled = 2'd1,
      runt          = 2'd2
   } drop_reason_e;

   // Outgoing metadata record
   typedef struct packed {
      logic         valid;
      port_t        port;
      tc_t          tc;
      logic         drop;
      drop_reason_e drop_reason;
      ethertype_t   ethertype;
      vid_t         vid;
   } rx_meta_t;

   // State names tell which header word is expected next
   typedef enum logic [2:0] {
      idle, skip_mac, etype, inner, payload
   } parse_state_e;

endpackage
